// ==== source/mpu_cfg_pkg.sv ====
//################################################
// Shared constants, types and the power-up register
// table for the MPU9250 sensor array configurator.
// Referenced by scoped names from RTL and testbench.
//################################################

package mpu_cfg_pkg;

  // Number of sensor lanes, one SPI bus each
  localparam int NUM_LANES = 3;

  // sclk divider width, one sclk period is 2**SCLK_DIV_BITS clk cycles
  localparam int SCLK_DIV_BITS = 4;

  // Hold counter width, 2**HOLD_BITS clk cycles of quiet bus after a word
  localparam int HOLD_BITS = 8;

  // Init table size and index width
  localparam int CFG_LEN      = 4;
  localparam int CFG_IDX_BITS = 2;

  // One register write, addr goes out first
  // Bit 7 of addr stays clear for a write
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
  } mpu_write_t;

  // Power-up register writes, issued in this order
  localparam mpu_write_t CFG_TABLE [CFG_LEN] = '{
    // PWR_MGMT_1, device reset
    '{addr: 8'h6B, data: 8'h80},
    // PWR_MGMT_1, auto-select best clock source
    '{addr: 8'h6B, data: 8'h01},
    // GYRO_CONFIG, full scale 2000 dps
    '{addr: 8'h1B, data: 8'h18},
    // ACCEL_CONFIG, full scale 16 g
    '{addr: 8'h1C, data: 8'h18}
  };

endpackage

// ==== source/spi_mpu_set.sv ====
//################################################
// Single-lane SPI register write engine for MPU9250.
// CPOL=1, CPHA=1, MSB first, 16-bit address+data word
// followed by a hold period, then a finish pulse.
//################################################

`timescale 1ns/1ps

module spi_mpu_set #(
  parameter int CLK_DIV   = 4,
  parameter int HOLD_BITS = 8
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic [7:0] addr,
  input  logic [7:0] data,
  output logic       sclk,
  output logic       busy,
  output logic       finish,
  output logic       mosi
);

  // Engine states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HALF,
    ST_SEND,
    ST_HOLD
  } state_t;

  state_t               state_q, state_d;
  // Divider counter, its MSB is the sclk level outside idle
  logic [CLK_DIV-1:0]   div_q, div_d;
  // Outgoing word, shifted left one bit per sclk period
  logic [15:0]          shift_q, shift_d;
  // Bits left to send, counts 15 down to 0
  logic [3:0]           bit_q, bit_d;
  logic [HOLD_BITS-1:0] hold_q, hold_d;
  logic                 mosi_q, mosi_d;
  logic                 finish_q, finish_d;

  // Idle high, otherwise follows the divider MSB
  assign sclk   = (state_q == ST_IDLE) | div_q[CLK_DIV-1];
  // Hold phase does not count as busy
  assign busy   = (state_q == ST_HALF) | (state_q == ST_SEND);
  assign finish = finish_q;
  assign mosi   = mosi_q;

  always_comb begin
    state_d  = state_q;
    div_d    = div_q;
    shift_d  = shift_q;
    bit_d    = bit_q;
    hold_d   = hold_q;
    mosi_d   = mosi_q;
    finish_d = 1'b0;

    case (state_q)
      ST_IDLE: begin
        // Park counters, bus quiet
        div_d  = '1;
        bit_d  = 4'hF;
        hold_d = '0;
        mosi_d = 1'b0;
        if (start) begin
          shift_d = {addr, data};
          state_d = ST_HALF;
        end
      end

      ST_HALF: begin
        // Count down half a period with sclk still high
        div_d = div_q - 1'b1;
        if (div_q == {1'b1, {(CLK_DIV-1){1'b0}}}) begin
          div_d   = '0;
          state_d = ST_SEND;
        end
      end

      ST_SEND: begin
        div_d = div_q + 1'b1;
        // sclk just fell, present the next bit
        if (div_q == '0) begin
          mosi_d  = shift_q[15];
          shift_d = {shift_q[14:0], 1'b0};
        end else if (div_q == '1) begin
          // End of a full sclk period
          bit_d = bit_q - 1'b1;
          if (bit_q == 4'h0) begin
            // Last bit done, sclk stays high from here
            div_d   = '1;
            mosi_d  = 1'b0;
            state_d = ST_HOLD;
          end
        end
      end

      ST_HOLD: begin
        hold_d = hold_q + 1'b1;
        if (hold_q == '1) begin
          finish_d = 1'b1;
          state_d  = ST_IDLE;
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= ST_IDLE;
      div_q    <= '1;
      bit_q    <= 4'hF;
      hold_q   <= '0;
      mosi_q   <= 1'b0;
      finish_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      div_q    <= div_d;
      bit_q    <= bit_d;
      hold_q   <= hold_d;
      mosi_q   <= mosi_d;
      finish_q <= finish_d;
    end
  end

  // Word register
  always_ff @(posedge clk) begin
    shift_q <= shift_d;
  end

  // Register writes only, read bit never set
  a_write_only: assert property (@(posedge clk) disable iff (rst)
    start |-> !addr[7]);

  // Sequencer must not restart a lane mid-transfer
  a_start_not_busy: assert property (@(posedge clk) disable iff (rst)
    start |-> !busy);

endmodule

// ==== source/mpu_init_seq.sv ====
//################################################
// Init sequencer, walks the power-up register table and
// starts the enabled SPI lanes once per entry, waiting
// for the finish join before moving to the next one.
//################################################

`timescale 1ns/1ps

module mpu_init_seq (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 cfg_start,
  input  logic [mpu_cfg_pkg::NUM_LANES-1:0]    lane_en,
  input  logic                                 all_done,
  output mpu_cfg_pkg::mpu_write_t              wr,
  output logic [mpu_cfg_pkg::NUM_LANES-1:0]    lane_start,
  output logic                                 cfg_busy,
  output logic                                 cfg_done
);

  // Sequencer states
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_WAIT
  } seq_state_t;

  seq_state_t                              state_q;
  // Current table entry
  logic [mpu_cfg_pkg::CFG_IDX_BITS-1:0]    idx_q;
  // Lane mask captured at cfg_start
  logic [mpu_cfg_pkg::NUM_LANES-1:0]       mask_q;
  logic                                    done_q;

  // Same byte pair goes to every lane
  assign wr         = mpu_cfg_pkg::CFG_TABLE[idx_q];
  // One-cycle start for the latched lanes
  assign lane_start = (state_q == SEQ_ISSUE) ? mask_q : '0;
  assign cfg_busy   = (state_q != SEQ_IDLE);
  assign cfg_done   = done_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= SEQ_IDLE;
      idx_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        SEQ_IDLE: begin
          // Start strobe only honored here
          if (cfg_start) begin
            idx_q   <= '0;
            state_q <= SEQ_ISSUE;
          end
        end

        SEQ_ISSUE: begin
          // No lanes enabled, nothing to wait for
          if (mask_q == '0) begin
            done_q  <= 1'b1;
            state_q <= SEQ_IDLE;
          end else begin
            state_q <= SEQ_WAIT;
          end
        end

        SEQ_WAIT: begin
          if (all_done) begin
            if (idx_q == mpu_cfg_pkg::CFG_IDX_BITS'(mpu_cfg_pkg::CFG_LEN - 1)) begin
              done_q  <= 1'b1;
              state_q <= SEQ_IDLE;
            end else begin
              // Next entry goes out in the following cycle
              idx_q   <= idx_q + 1'b1;
              state_q <= SEQ_ISSUE;
            end
          end
        end

        default: state_q <= SEQ_IDLE;
      endcase
    end
  end

  // Lane mask latch
  always_ff @(posedge clk) begin
    if (state_q == SEQ_IDLE && cfg_start) begin
      mask_q <= lane_en;
    end
  end

  // Join completes only while an entry is outstanding
  a_done_in_wait: assert property (@(posedge clk) disable iff (rst)
    all_done |-> (state_q == SEQ_WAIT));

endmodule

// ==== source/mpu_finish_join.sv ====
//################################################
// Finish join, tracks which started lanes are still
// transferring and pulses all_done once they are all
// through with the current table entry.
//################################################

`timescale 1ns/1ps

module mpu_finish_join (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [mpu_cfg_pkg::NUM_LANES-1:0] lane_start,
  input  logic [mpu_cfg_pkg::NUM_LANES-1:0] finish,
  output logic                              all_done
);

  // Lanes started but not yet finished
  logic [mpu_cfg_pkg::NUM_LANES-1:0] pending_q, pending_d;
  logic                              done_q;

  // New start replaces the mask, otherwise drain on finish
  always_comb begin
    if (lane_start != '0) begin
      pending_d = lane_start;
    end else begin
      pending_d = pending_q & ~finish;
    end
  end

  assign all_done = done_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= '0;
      done_q    <= 1'b0;
    end else begin
      pending_q <= pending_d;
      // Pulse only on a nonempty mask going empty
      done_q    <= (pending_q != '0) && (pending_d == '0);
    end
  end

  // Finish from a lane nobody is waiting on
  a_finish_pending: assert property (@(posedge clk) disable iff (rst)
    (finish & ~pending_q) == '0);

  // Next entry only after the join has drained
  a_start_drained: assert property (@(posedge clk) disable iff (rst)
    (lane_start != '0) |-> (pending_q == '0));

endmodule

// ==== source/mpu_array_cfg.sv ====
//################################################
// Top level of the MPU9250 array configurator. One init
// sequencer drives a row of SPI write engines, one per
// sensor lane, and a join collects their finish pulses.
//################################################

`timescale 1ns/1ps

module mpu_array_cfg (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              cfg_start,
  input  logic [mpu_cfg_pkg::NUM_LANES-1:0] lane_en,
  output logic [mpu_cfg_pkg::NUM_LANES-1:0] sclk,
  output logic [mpu_cfg_pkg::NUM_LANES-1:0] mosi,
  output logic                              cfg_busy,
  output logic                              cfg_done
);

  // Shared register write for all lanes
  mpu_cfg_pkg::mpu_write_t           wr;
  // Per-lane start strobes from the sequencer
  logic [mpu_cfg_pkg::NUM_LANES-1:0] lane_start;
  // Per-lane finish pulses into the join
  logic [mpu_cfg_pkg::NUM_LANES-1:0] finish;
  logic                              all_done;

  mpu_init_seq u_mpu_init_seq (
    .clk        (clk),
    .rst        (rst),
    .cfg_start  (cfg_start),
    .lane_en    (lane_en),
    .all_done   (all_done),
    .wr         (wr),
    .lane_start (lane_start),
    .cfg_busy   (cfg_busy),
    .cfg_done   (cfg_done)
  );

  // One write engine per sensor
  for (genvar i = 0; i < mpu_cfg_pkg::NUM_LANES; i++) begin : g_lane
    spi_mpu_set #(
      .CLK_DIV   (mpu_cfg_pkg::SCLK_DIV_BITS),
      .HOLD_BITS (mpu_cfg_pkg::HOLD_BITS)
    ) u_spi_mpu_set (
      .clk    (clk),
      .rst    (rst),
      .start  (lane_start[i]),
      .addr   (wr.addr),
      .data   (wr.data),
      .sclk   (sclk[i]),
      .busy   (),
      .finish (finish[i]),
      .mosi   (mosi[i])
    );
  end

  mpu_finish_join u_mpu_finish_join (
    .clk        (clk),
    .rst        (rst),
    .lane_start (lane_start),
    .finish     (finish),
    .all_done   (all_done)
  );

endmodule

// ==== dv/spi_mpu_model.sv ====
//################################################
// Passive MPU9250 SPI model for the testbench.
// Samples mosi on rising sclk, packs 16-bit words and
// counts sclk edges. clr empties the capture memory.
//################################################

`timescale 1ns/1ps

module spi_mpu_model #(
  parameter int MAX_WORDS = 8
) (
  input  logic                       clr,
  input  logic                       sclk,
  input  logic                       mosi,
  output logic [MAX_WORDS-1:0][15:0] words,
  output logic [7:0]                 word_cnt,
  output logic [15:0]                edge_cnt
);

  // Bits gathered for the word in flight
  logic [15:0] shift;
  // Position inside the current word
  logic [3:0]  bit_cnt;

  // CPHA=1, data valid on the rising edge
  always @(posedge sclk or posedge clr) begin
    if (clr) begin
      words    <= '0;
      word_cnt <= '0;
      edge_cnt <= '0;
      shift    <= '0;
      bit_cnt  <= '0;
    end else begin
      edge_cnt <= edge_cnt + 1'b1;
      shift    <= {shift[14:0], mosi};
      bit_cnt  <= bit_cnt + 1'b1;
      // Sixteenth bit closes the word
      if (bit_cnt == 4'hF) begin
        // Extra words only bump the count
        if (word_cnt < MAX_WORDS) begin
          words[word_cnt] <= {shift[14:0], mosi};
        end
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== dv/tb_mpu_array_cfg.sv ====
//################################################
// Directed testbench for the MPU9250 array configurator.
// One SPI model per lane captures the words sent, and
// each test compares them with the register table.
//################################################

`timescale 1ns/1ps

module tb_mpu_array_cfg;

  logic                              clk;
  logic                              rst;
  logic                              cfg_start;
  logic [mpu_cfg_pkg::NUM_LANES-1:0] lane_en;
  logic [mpu_cfg_pkg::NUM_LANES-1:0] sclk;
  logic [mpu_cfg_pkg::NUM_LANES-1:0] mosi;
  logic                              cfg_busy;
  logic                              cfg_done;
  logic                              model_clr;

  // Capture state of the per-lane models
  logic [mpu_cfg_pkg::NUM_LANES-1:0][7:0][15:0] cap_words;
  logic [mpu_cfg_pkg::NUM_LANES-1:0][7:0]       word_cnt;
  logic [mpu_cfg_pkg::NUM_LANES-1:0][15:0]      edge_cnt;

  int          error_cnt;
  int          check_cnt;
  int          done_cnt = 0;
  logic [31:0] rng_state;

  mpu_array_cfg u_mpu_array_cfg (
    .clk       (clk),
    .rst       (rst),
    .cfg_start (cfg_start),
    .lane_en   (lane_en),
    .sclk      (sclk),
    .mosi      (mosi),
    .cfg_busy  (cfg_busy),
    .cfg_done  (cfg_done)
  );

  // One sensor per lane
  for (genvar i = 0; i < mpu_cfg_pkg::NUM_LANES; i++) begin : g_model
    spi_mpu_model u_spi_mpu_model (
      .clr      (model_clr),
      .sclk     (sclk[i]),
      .mosi     (mosi[i]),
      .words    (cap_words[i]),
      .word_cnt (word_cnt[i]),
      .edge_cnt (edge_cnt[i])
    );
  end

  always #5 clk = ~clk;

  // Running count of cfg_done pulses, sampled mid-cycle
  always @(negedge clk) begin
    if (cfg_done) begin
      done_cnt++;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      error_cnt++;
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Random mask with at least one lane on and one lane off
  task automatic pick_mask(output logic [mpu_cfg_pkg::NUM_LANES-1:0] mask);
    int tries;
    mask = '0;
    for (tries = 0; tries < 32; tries++) begin
      rng_state = xorshift32(rng_state);
      mask = rng_state[mpu_cfg_pkg::NUM_LANES-1:0];
      if (mask != '0 && mask != '1) break;
    end
    if (mask == '0 || mask == '1) mask = 'b1;
  endtask

  task automatic clear_models();
    model_clr = 1'b1;
    @(posedge clk);
    #1;
    model_clr = 1'b0;
  endtask

  task automatic start_pulse(input logic [mpu_cfg_pkg::NUM_LANES-1:0] mask);
    lane_en   = mask;
    cfg_start = 1'b1;
    @(posedge clk);
    #1;
    cfg_start = 1'b0;
  endtask

  task automatic wait_cfg_done();
    int cycles;
    bit seen;
    seen = 1'b0;
    for (cycles = 0; cycles < 20000 && !seen; cycles++) begin
      @(posedge clk);
      #1;
      seen = cfg_done;
    end
    if (!seen) begin
      $display("Timeout: cfg_done did not arrive within 20000 cycles");
      error_cnt++;
    end
  endtask

  // Enabled lanes hold the whole table in order, others stay silent
  task automatic check_lanes(input logic [mpu_cfg_pkg::NUM_LANES-1:0] mask);
    for (int i = 0; i < mpu_cfg_pkg::NUM_LANES; i++) begin
      if (mask[i]) begin
        check_val($sformatf("lane%0d word_cnt", i), word_cnt[i], mpu_cfg_pkg::CFG_LEN);
        check_val($sformatf("lane%0d edge_cnt", i), edge_cnt[i],
                  16 * mpu_cfg_pkg::CFG_LEN);
        for (int k = 0; k < mpu_cfg_pkg::CFG_LEN; k++) begin
          check_val($sformatf("lane%0d word%0d", i, k), cap_words[i][k],
                    {mpu_cfg_pkg::CFG_TABLE[k].addr, mpu_cfg_pkg::CFG_TABLE[k].data});
        end
      end else begin
        check_val($sformatf("lane%0d word_cnt", i), word_cnt[i], 0);
        check_val($sformatf("lane%0d edge_cnt", i), edge_cnt[i], 0);
      end
    end
  endtask

  // Full run with one mask, then exactly one cfg_done expected
  task automatic run_cfg(input logic [mpu_cfg_pkg::NUM_LANES-1:0] mask);
    int done_base;
    clear_models();
    done_base = done_cnt;
    start_pulse(mask);
    wait_cfg_done();
    repeat (4) @(posedge clk);
    #1;
    check_val("cfg_done count", done_cnt - done_base, 1);
    check_val("cfg_busy", cfg_busy, 0);
    check_lanes(mask);
  endtask

  task automatic after_reset();
    check_val("sclk", sclk, {mpu_cfg_pkg::NUM_LANES{1'b1}});
    check_val("mosi", mosi, 0);
    check_val("cfg_busy", cfg_busy, 0);
    check_val("cfg_done", cfg_done, 0);
  endtask

  task automatic all_lanes();
    run_cfg('1);
  endtask

  task automatic random_lanes();
    logic [mpu_cfg_pkg::NUM_LANES-1:0] mask;
    pick_mask(mask);
    run_cfg(mask);
  endtask

  task automatic no_lanes();
    run_cfg('0);
  endtask

  // Second strobe mid-run with another mask must leave no trace
  task automatic restart_ignored();
    int done_base;
    clear_models();
    done_base = done_cnt;
    start_pulse('1);
    repeat (20) @(posedge clk);
    #1;
    check_val("cfg_busy", cfg_busy, 1);
    start_pulse('b1);
    wait_cfg_done();
    // Long enough for a restarted run to show up as busy
    repeat (600) @(posedge clk);
    #1;
    check_val("cfg_busy", cfg_busy, 0);
    check_val("cfg_done count", done_cnt - done_base, 1);
    check_lanes('1);
  endtask

  task automatic back_to_back();
    logic [mpu_cfg_pkg::NUM_LANES-1:0] mask_a;
    logic [mpu_cfg_pkg::NUM_LANES-1:0] mask_b;
    pick_mask(mask_a);
    pick_mask(mask_b);
    if (mask_b == mask_a) mask_b = ~mask_a;
    run_cfg(mask_a);
    run_cfg(mask_b);
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    cfg_start = 1'b0;
    lane_en   = '0;
    model_clr = 1'b1;
    error_cnt = 0;
    check_cnt = 0;
    rng_state = 32'd60;
    repeat (2) @(posedge clk);
    #1;
    rst       = 1'b0;
    model_clr = 1'b0;

    after_reset();
    all_lanes();
    random_lanes();
    no_lanes();
    restart_ignored();
    back_to_back();

    $display("Checks run: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
source/mpu_cfg_pkg.sv
source/spi_mpu_set.sv
source/mpu_init_seq.sv
source/mpu_finish_join.sv
source/mpu_array_cfg.sv
dv/spi_mpu_model.sv
dv/tb_mpu_array_cfg.sv

// ==== Makefile ====
# Verilator build and run for the MPU9250 array configurator

VERILATOR ?= verilator
TOP       ?= tb_mpu_array_cfg
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD_DIR)/$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	@grep -q "TESTS PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
